// ==== Makefile ====
TOP       ?= tb_chord_recognizer
VERILATOR ?= verilator
FLAGS     ?= --binary -j 0 -Wno-fatal
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the output for the pass message"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "all tests passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== list.f ====
logic/audio_pkg.sv
logic/note_pkg.sv
logic/mic_spi_receiver.sv
logic/period_meter.sv
logic/note_classifier.sv
logic/note_stabilizer.sv
logic/chord_detector.sv
logic/note_display.sv
logic/chord_recognizer_top.sv
verification/mic_adc_model.sv
verification/tb_chord_recognizer.sv

// ==== logic/audio_pkg.sv ====
package audio_pkg;

    // --------------------------------------------------
    // Converter serial frame
    // --------------------------------------------------

    localparam int sample_width     = 12;  // Converter resolution
    localparam int spi_frame_bits   = 16;  // Four zeros, then 12 data bits MSB first
    localparam int sck_half_cycles  = 2;
    localparam int cs_gap_cycles    = 4;   // cs high between frames
    localparam int spi_bit_cycles   = 2 * sck_half_cycles;
    localparam int spi_frame_cycles = spi_frame_bits * spi_bit_cycles + cs_gap_cycles;
    localparam int spi_phase_width  = $clog2(spi_frame_cycles);

    localparam logic [sample_width-1:0] crossing_threshold = 12'h800;  // Mid level

    // --------------------------------------------------
    // Period measurement and note windows
    // --------------------------------------------------

    localparam int period_width = 24;  // Saturates at all ones

    // Fourth octave, frequency times 100
    localparam int freq_100_c  = 26163;
    localparam int freq_100_cs = 27718;
    localparam int freq_100_d  = 29366;
    localparam int freq_100_ds = 31113;
    localparam int freq_100_e  = 32963;
    localparam int freq_100_f  = 34923;
    localparam int freq_100_fs = 36999;
    localparam int freq_100_g  = 39200;
    localparam int freq_100_gs = 41530;
    localparam int freq_100_a  = 44000;
    localparam int freq_100_as = 46616;
    localparam int freq_100_b  = 49388;

    localparam int tolerance_percent = 2;

    // Nominal period is clk Hz * 100 / freq_100
    function automatic logic [period_width-1:0] period_low(input int clk_mhz, input int freq_100);
        longint nominal;
        nominal = longint'(clk_mhz) * 64'd100_000_000 / freq_100;
        return period_width'(nominal * (100 - tolerance_percent) / 100);
    endfunction

    function automatic logic [period_width-1:0] period_high(input int clk_mhz, input int freq_100);
        longint nominal;
        nominal = longint'(clk_mhz) * 64'd100_000_000 / freq_100;
        return period_width'(nominal * (100 + tolerance_percent) / 100);
    endfunction

endpackage

// ==== logic/chord_detector.sv ====
`timescale 1ns/10ps

module chord_detector
(
    input  logic            clk,
    input  logic            reset,
    input  note_pkg::note_t stable_note,
    output logic            major,
    output logic            minor
);

    import note_pkg::*;

    chord_state_t state;
    chord_state_t next_state;

    // --------------------------------------------------
    // Next state, other notes leave it alone
    // --------------------------------------------------

    always_comb
    begin
        next_state = state;

        case (state)
            wait_c:
                if (stable_note == note_c)
                    next_state = wait_third;
            wait_third:
                if (stable_note == note_e)
                    next_state = wait_g_major;
                else if (stable_note == note_ds)
                    next_state = wait_g_minor;
            wait_g_major:
                if (stable_note == note_g)
                    next_state = c_major;
            wait_g_minor:
                if (stable_note == note_g)
                    next_state = c_minor;
            c_major, c_minor:
                if (stable_note == note_c)
                    next_state = wait_third;  // New root, start over
            default:
                next_state = wait_c;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= wait_c;
            major <= 1'b0;
            minor <= 1'b0;
        end
        else
        begin
            state <= next_state;
            major <= state == c_major;  // One cycle behind the state
            minor <= state == c_minor;
        end
    end

endmodule

// ==== logic/chord_recognizer_top.sv ====
`timescale 1ns/10ps

module chord_recognizer_top
#(
    parameter int clk_mhz      = 50,
    parameter int stable_width = 18   // Hold count is 2**stable_width cycles
)
(
    input  logic       clk,
    input  logic       reset,
    input  logic       sdo,
    output logic       cs,
    output logic       sck,
    output logic       major,
    output logic       minor,
    output logic [7:0] abcdefgh
);

    import audio_pkg::*;
    import note_pkg::*;

    logic [sample_width-1:0] sample;
    logic                    sample_valid;
    logic [period_width-1:0] period;
    note_t                   note;
    note_t                   stable_note;

    // --------------------------------------------------
    // Microphone to note
    // --------------------------------------------------

    mic_spi_receiver u_receiver
    (
        .clk          (clk),
        .reset        (reset),
        .sdo          (sdo),
        .cs           (cs),
        .sck          (sck),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    period_meter u_meter
    (
        .clk          (clk),
        .reset        (reset),
        .sample       (sample),
        .sample_valid (sample_valid),
        .period       (period)
    );

    note_classifier #(.clk_mhz(clk_mhz)) u_classifier
    (
        .clk    (clk),
        .reset  (reset),
        .period (period),
        .note   (note)
    );

    note_stabilizer #(.stable_width(stable_width)) u_stabilizer
    (
        .clk         (clk),
        .reset       (reset),
        .note        (note),
        .stable_note (stable_note)
    );

    // --------------------------------------------------
    // Chord and display
    // --------------------------------------------------

    chord_detector u_chord
    (
        .clk         (clk),
        .reset       (reset),
        .stable_note (stable_note),
        .major       (major),
        .minor       (minor)
    );

    note_display u_display
    (
        .clk         (clk),
        .reset       (reset),
        .stable_note (stable_note),
        .abcdefgh    (abcdefgh)
    );

endmodule

// ==== logic/mic_spi_receiver.sv ====
`timescale 1ns/10ps

module mic_spi_receiver
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               sdo,
    output logic                               cs,
    output logic                               sck,
    output logic [audio_pkg::sample_width-1:0] sample,
    output logic                               sample_valid
);

    import audio_pkg::*;

    logic [spi_phase_width-1:0] phase;      // Position inside the 68 cycle frame
    logic [spi_phase_width-1:0] bit_phase;
    logic                       active;
    logic                       sck_next;
    logic                       rise;
    logic                       last_bit;
    logic [sample_width-2:0]    shift;      // Leading zeros fall out the top

    // --------------------------------------------------
    // Frame timing
    // --------------------------------------------------

    always_comb
    begin
        active    = phase >= cs_gap_cycles;  // Gap comes first in the frame
        bit_phase = phase - spi_phase_width'(cs_gap_cycles);
        sck_next  = active && (bit_phase % spi_bit_cycles) >= sck_half_cycles;
        rise      = sck_next && !sck;
        last_bit  = rise && (bit_phase / spi_bit_cycles) == spi_frame_bits - 1;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            phase        <= '0;
            cs           <= 1'b1;
            sck          <= 1'b0;
            sample_valid <= 1'b0;
        end
        else
        begin
            phase        <= (phase == spi_frame_cycles - 1) ? '0 : phase + 1'b1;
            cs           <= !active;
            sck          <= sck_next;
            sample_valid <= last_bit;  // One cycle after the final bit
        end
    end

    // Data path, sampled as sck goes high
    always_ff @(posedge clk)
    begin
        if (rise)
            shift <= {shift[sample_width-3:0], sdo};
        if (last_bit)
            sample <= {shift, sdo};
    end

endmodule

// ==== logic/note_classifier.sv ====
`timescale 1ns/10ps

module note_classifier
#(
    parameter int clk_mhz = 50
)
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic [audio_pkg::period_width-1:0] period,
    output note_pkg::note_t                    note
);

    import audio_pkg::*;
    import note_pkg::*;

    note_t match;

    // Inside the window at the base frequency or one octave up
    function automatic logic in_window(input logic [period_width-1:0] p, input int freq_100);
        return (p > period_low(clk_mhz, freq_100) && p < period_high(clk_mhz, freq_100))
            || (p > period_low(clk_mhz, 2 * freq_100) && p < period_high(clk_mhz, 2 * freq_100));
    endfunction

    always_comb
    begin
        match[11] = in_window(period, freq_100_c);
        match[10] = in_window(period, freq_100_cs);
        match[9]  = in_window(period, freq_100_d);
        match[8]  = in_window(period, freq_100_ds);
        match[7]  = in_window(period, freq_100_e);
        match[6]  = in_window(period, freq_100_f);
        match[5]  = in_window(period, freq_100_fs);
        match[4]  = in_window(period, freq_100_g);
        match[3]  = in_window(period, freq_100_gs);
        match[2]  = in_window(period, freq_100_a);
        match[1]  = in_window(period, freq_100_as);
        match[0]  = in_window(period, freq_100_b);
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            note <= no_note;
        else if (match != no_note && (match & (match - 1'b1)) == no_note)
            note <= match;
        else
            note <= no_note;  // Overlapping windows or nothing heard
    end

endmodule

// ==== logic/note_display.sv ====
`timescale 1ns/10ps

module note_display
(
    input  logic            clk,
    input  logic            reset,
    input  note_pkg::note_t stable_note,
    output logic [7:0]      abcdefgh
);

    import note_pkg::*;

    //   --a--
    //  |     |
    //  f     b
    //   --g--
    //  e     c
    //  |     |
    //   --d--  h

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            abcdefgh <= blank_segments;
        else if (stable_note != no_note)
            abcdefgh <= segment_pattern(stable_note);  // Silence keeps the last letter
    end

endmodule

// ==== logic/note_pkg.sv ====
package note_pkg;

    localparam int note_count = 12;

    typedef logic [note_count-1:0] note_t;  // One-hot, C at the top

    localparam note_t note_c  = 12'b1000_0000_0000;
    localparam note_t note_cs = 12'b0100_0000_0000;
    localparam note_t note_d  = 12'b0010_0000_0000;
    localparam note_t note_ds = 12'b0001_0000_0000;
    localparam note_t note_e  = 12'b0000_1000_0000;
    localparam note_t note_f  = 12'b0000_0100_0000;
    localparam note_t note_fs = 12'b0000_0010_0000;
    localparam note_t note_g  = 12'b0000_0001_0000;
    localparam note_t note_gs = 12'b0000_0000_1000;
    localparam note_t note_a  = 12'b0000_0000_0100;
    localparam note_t note_as = 12'b0000_0000_0010;
    localparam note_t note_b  = 12'b0000_0000_0001;
    localparam note_t no_note = 12'b0000_0000_0000;

    // --------------------------------------------------
    // Seven-segment letters, active low abcdefgh
    // --------------------------------------------------

    localparam logic [7:0] blank_segments = 8'hFF;

    function automatic logic [7:0] segment_pattern(input note_t note);
        case (note)
            note_c:  return 8'b01100011;
            note_cs: return 8'b01100010;  // h is the sharp dot
            note_d:  return 8'b10000101;
            note_ds: return 8'b10000100;
            note_e:  return 8'b01100001;
            note_f:  return 8'b01110001;
            note_fs: return 8'b01110000;
            note_g:  return 8'b01000011;
            note_gs: return 8'b01000010;
            note_a:  return 8'b00010001;
            note_as: return 8'b00010000;
            note_b:  return 8'b11000001;
            default: return blank_segments;
        endcase
    endfunction

    typedef enum logic [2:0]
    {
        wait_c,
        wait_third,    // E for major, D# for minor
        wait_g_major,
        wait_g_minor,
        c_major,
        c_minor
    } chord_state_t;

endpackage

// ==== logic/note_stabilizer.sv ====
`timescale 1ns/10ps

module note_stabilizer
#(
    parameter int stable_width = 18
)
(
    input  logic            clk,
    input  logic            reset,
    input  note_pkg::note_t note,
    output note_pkg::note_t stable_note
);

    import note_pkg::*;

    note_t                   d_note;     // Note one cycle ago
    logic [stable_width-1:0] hold_cnt;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            d_note      <= no_note;
            hold_cnt    <= '0;
            stable_note <= no_note;
        end
        else
        begin
            d_note <= note;

            if (note == d_note)
                hold_cnt <= hold_cnt + 1'b1;
            else
                hold_cnt <= '0;  // Any change restarts the hold

            if (&hold_cnt)
                stable_note <= d_note;
        end
    end

endmodule

// ==== logic/period_meter.sv ====
`timescale 1ns/10ps

module period_meter
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic [audio_pkg::sample_width-1:0] sample,
    input  logic                               sample_valid,
    output logic [audio_pkg::period_width-1:0] period
);

    import audio_pkg::*;

    logic [sample_width-1:0] prev_sample;  // Last accepted sample
    logic [period_width-1:0] count;
    logic                    crossing;

    // Upward pass through the mid level
    assign crossing = sample_valid
                   && sample > crossing_threshold
                   && prev_sample < crossing_threshold;

    // --------------------------------------------------
    // Crossing history and cycle count
    // --------------------------------------------------

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            prev_sample <= '1;  // Treated as high, no crossing right after reset
            count       <= '0;
            period      <= '0;
        end
        else
        begin
            if (sample_valid)
                prev_sample <= sample;

            if (crossing)
            begin
                period <= count;
                count  <= '0;
            end
            else if (count != '1)  // Hold at full scale
            begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// ==== verification/mic_adc_model.sv ====
`timescale 1ns/10ps

module mic_adc_model
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               cs,
    input  logic                               sck,
    input  logic [audio_pkg::period_width-1:0] half_period,  // 0 is silence
    output logic                               sdo
);

    import audio_pkg::*;

    localparam logic [sample_width-1:0] level_high = 12'hC00;
    localparam logic [sample_width-1:0] level_low  = 12'h400;

    logic [sample_width-1:0]   level;
    logic [period_width-1:0]   tone_cnt;
    logic [spi_frame_bits-1:0] word;
    logic                      cs_prev;
    logic                      sck_prev;

    // Square wave tone
    always @(posedge clk or posedge reset)
    begin
        if (reset || half_period == 0)
        begin
            level    <= level_low;
            tone_cnt <= '0;
        end
        else if (tone_cnt >= half_period - 1'b1)
        begin
            level    <= (level == level_high) ? level_low : level_high;
            tone_cnt <= '0;
        end
        else
        begin
            tone_cnt <= tone_cnt + 1'b1;
        end
    end

    // --------------------------------------------------
    // Serial side of the converter
    // --------------------------------------------------

    always @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            cs_prev  <= 1'b1;
            sck_prev <= 1'b0;
            word     <= '0;
        end
        else
        begin
            cs_prev  <= cs;
            sck_prev <= sck;
            if (cs_prev && !cs)
                word <= {4'b0000, level};  // Conversion starts as cs falls
            else if (!cs && sck_prev && !sck)
                word <= word << 1;         // Next bit after sck falls
        end
    end

    assign sdo = word[spi_frame_bits-1];

endmodule

// ==== verification/tb_chord_recognizer.sv ====
`timescale 1ns/10ps

module tb_chord_recognizer;

    import audio_pkg::*;

    localparam int tb_clk_mhz     = 4;
    localparam int timeout_cycles = 3_000_000;
    localparam int gap_cycles     = 20_000;  // Longer than the slowest note period
    localparam int display_limit  = 50_000;

    // Segment masks with a at the top and the dot h at the bottom
    localparam logic [7:0] seg_a = 8'b1000_0000;
    localparam logic [7:0] seg_b = 8'b0100_0000;
    localparam logic [7:0] seg_c = 8'b0010_0000;
    localparam logic [7:0] seg_d = 8'b0001_0000;
    localparam logic [7:0] seg_e = 8'b0000_1000;
    localparam logic [7:0] seg_f = 8'b0000_0100;
    localparam logic [7:0] seg_g = 8'b0000_0010;
    localparam logic [7:0] seg_h = 8'b0000_0001;

    // Active low letters built from the lit segments
    localparam logic [7:0] letter_a  = ~(seg_a | seg_b | seg_c | seg_e | seg_f | seg_g);
    localparam logic [7:0] letter_c  = ~(seg_a | seg_d | seg_e | seg_f);
    localparam logic [7:0] letter_ds = ~(seg_b | seg_c | seg_d | seg_e | seg_g | seg_h);
    localparam logic [7:0] letter_e  = ~(seg_a | seg_d | seg_e | seg_f | seg_g);
    localparam logic [7:0] letter_g  = ~(seg_a | seg_c | seg_d | seg_e | seg_f);
    localparam logic [7:0] all_dark  = 8'hFF;

    logic                    clk;
    logic                    reset;
    logic                    sdo;
    logic                    cs;
    logic                    sck;
    logic                    major;
    logic                    minor;
    logic [7:0]              abcdefgh;
    logic [period_width-1:0] half_period;

    int value_errors = 0;
    int wait_errors  = 0;
    int cycle_count  = 0;

    chord_recognizer_top #(.clk_mhz(tb_clk_mhz), .stable_width(12)) u_dut
    (
        .clk      (clk),
        .reset    (reset),
        .sdo      (sdo),
        .cs       (cs),
        .sck      (sck),
        .major    (major),
        .minor    (minor),
        .abcdefgh (abcdefgh)
    );

    mic_adc_model u_adc
    (
        .clk         (clk),
        .reset       (reset),
        .cs          (cs),
        .sck         (sck),
        .half_period (half_period),
        .sdo         (sdo)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("Run stopped, the tests did not finish within %0d cycles", timeout_cycles);
            $display("tests failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("[ERROR] %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
            value_errors++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;  // Drive and sample just after the edge
    endtask

    task automatic play_silence(input int cycles);
        half_period = '0;
        wait_cycles(cycles);
    endtask

    task automatic play_tone(input int freq_100);
        int half;
        half = tb_clk_mhz * 100_000_000 / (2 * freq_100);
        play_silence(gap_cycles);  // Keeps the first period out of every window
        half_period = period_width'(half);
        wait_cycles(16 * half);    // Eight tone periods
    endtask

    task automatic wait_display(input logic [7:0] expected, input string name);
        int waited;
        waited = 0;
        while (abcdefgh !== expected && waited < display_limit)
        begin
            wait_cycles(1);
            waited++;
        end
        if (abcdefgh !== expected)
        begin
            $display("The display never showed note %s within %0d cycles", name, display_limit);
            wait_errors++;
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------

    task automatic test_reset();
        check_value(cs, 1'b1, "cs after reset");
        check_value(sck, 1'b0, "sck after reset");
        check_value(major, 1'b0, "major after reset");
        check_value(minor, 1'b0, "minor after reset");
        check_value(abcdefgh, all_dark, "display after reset");
    endtask

    task automatic test_single_note();
        play_tone(freq_100_a);
        wait_display(letter_a, "A");
        play_silence(2 * gap_cycles);
        check_value(abcdefgh, letter_a, "A kept during silence");
    endtask

    task automatic test_octave();
        play_tone(2 * freq_100_e);
        wait_display(letter_e, "E one octave up");
    endtask

    task automatic test_c_major();
        play_tone(freq_100_c);
        wait_display(letter_c, "C");
        play_tone(freq_100_e);
        wait_display(letter_e, "E");
        play_tone(freq_100_g);
        wait_display(letter_g, "G");
        wait_cycles(2);  // major trails the display by one cycle
        check_value(major, 1'b1, "major after C E G");
        check_value(minor, 1'b0, "minor after C E G");
        play_tone(freq_100_c);
        wait_display(letter_c, "C after chord");
        wait_cycles(2);
        check_value(major, 1'b0, "major after new C");
        check_value(minor, 1'b0, "minor after new C");
    endtask

    task automatic test_c_minor();
        play_tone(freq_100_c);
        wait_display(letter_c, "C");
        play_tone(freq_100_ds);
        wait_display(letter_ds, "D#");
        play_tone(freq_100_g);
        wait_display(letter_g, "G");
        wait_cycles(2);
        check_value(minor, 1'b1, "minor after C D# G");
        check_value(major, 1'b0, "major after C D# G");
    endtask

    // Runs after the C minor chord, so G and minor stay up
    task automatic test_out_of_tolerance();
        play_tone(freq_100_f * 103 / 100);  // 3 percent sharp F
        check_value(abcdefgh, letter_g, "display after detuned F");
        check_value(major, 1'b0, "major after detuned F");
        check_value(minor, 1'b1, "minor after detuned F");
    endtask

    initial
    begin
        reset       = 1'b1;
        half_period = '0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;

        test_reset();
        test_single_note();
        test_octave();
        test_c_major();
        test_c_minor();
        test_out_of_tolerance();

        $display("Value errors: %0d, display timeouts: %0d", value_errors, wait_errors);
        if (value_errors == 0 && wait_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule
